/* source/capi_pkg.sv */
package capi_pkg;

  // Host command codes, as carried on the 13-bit command bus
  typedef enum logic [12:0] {
    INVALID    = 13'h0000,  // Idle value on the command bus
    READ_CL_NA = 13'h0A00   // Cache-line read, no allocation
  } command_opcode;

  // Host response codes
  typedef enum logic [7:0] {
    DONE   = 8'h00,  // Command completed
    AERROR = 8'h01,  // Address translation error
    FAILED = 8'h08,  // Command failed, may be retried
    PAGED  = 8'h0A   // Page fault pending
  } response_code;

  // Command and response tag
  typedef logic [7:0] tag_t;

  // Tag reserved for the WED read
  localparam tag_t WED_TAG = 8'h10;

  // Tag driven while no command is presented
  localparam tag_t INVALID_TAG = 8'hFF;

  // One full cache line holds the WED
  localparam logic [11:0] WED_READ_SIZE = 12'd128;

  // Commands the host accepts before returning a credit
  localparam int HOST_CREDITS = 2;

  // Counter width able to hold 0 to HOST_CREDITS
  localparam int CREDIT_WIDTH = $clog2(HOST_CREDITS + 1);

endpackage

/* source/wed_pkg.sv */
package wed_pkg;

  // WED fetch FSM states
  typedef enum logic [2:0] {
    WED_RESET,                // First cycle out of reset
    WED_IDLE,                 // Waiting for enable, or record published
    WED_REQ,                  // Read command presented
    WED_WAITING_FOR_REQUEST,  // Collecting line halves until response
    WED_RETRY,                // Failed response, one attempt used
    WED_DONE_REQ,             // Publishing the record
    WED_ERROR                 // Attempts exhausted
  } wed_state;

  // Decoded WED, first half of the cache line
  typedef struct packed {
    logic [0:63]  item_count;
    logic [0:63]  source_address;
    logic [0:63]  dest_address;
    logic [0:63]  flags;
    logic [0:255] reserved;
  } wed_record;

  // Read attempts before the error is raised
  localparam int WED_MAX_TRIES = 3;

  // Width of the failed-attempt counter
  localparam int TRY_WIDTH = $clog2(WED_MAX_TRIES + 1);

  // Line bit 0 is the most significant bit of the first word.
  // Only the first 512 bits carry WED content; the second half is
  // fetched with the line but not decoded.
  function automatic wed_record map_to_wed(input logic [0:1023] line);
    wed_record rec;
    rec.item_count     = line[0:63];
    rec.source_address = line[64:127];
    rec.dest_address   = line[128:191];
    rec.flags          = line[192:255];
    rec.reserved       = line[256:511];
    return rec;
  endfunction

endpackage

/* source/command_if.sv */
`timescale 1ns/1ns

interface command_if;

  import capi_pkg::*;

  logic          valid;    // Command presented
  logic          ready;    // Holding register empty
  command_opcode opcode;
  logic [0:63]   address;  // Host effective address
  tag_t          tag;
  logic [11:0]   size;     // Bytes

  modport source (output valid, output opcode, output address, output tag, output size,
                  input ready);

  modport sink (input valid, input opcode, input address, input tag, input size,
                output ready);

endinterface

/* source/buffer_if.sv */
`timescale 1ns/1ns

interface buffer_if;

  import capi_pkg::*;

  logic         write_valid;
  tag_t         write_tag;
  logic [5:0]   write_address;  // Half-line index within the transfer
  logic [0:511] write_data;

  modport driver (output write_valid, output write_tag, output write_address,
                  output write_data);

  modport listener (input write_valid, input write_tag, input write_address,
                    input write_data);

endinterface

/* source/wed_control.sv */
`timescale 1ns/1ns

module wed_control (
  input  logic                   clock,
  input  logic                   rstn,
  input  logic                   enabled,
  input  logic [0:63]            wed_address,
  buffer_if.listener             buffer_in,
  input  logic                   response_valid,
  input  capi_pkg::tag_t         response_tag,
  input  capi_pkg::response_code response_code,
  command_if.source              command_out,
  output logic                   wed_valid,
  output logic                   wed_error,
  output wed_pkg::wed_record     wed_request
);

  import capi_pkg::*;
  import wed_pkg::*;

  wed_state             current_state;
  wed_state             next_state;
  logic [0:1023]        wed_line;      // Assembled cache line
  logic [TRY_WIDTH-1:0] try_count;     // Failed attempts so far
  logic                 wed_response;  // Response for the WED read
  logic                 line_write;    // Buffer write for the WED read
  logic                 command_taken;

  assign wed_response  = response_valid && (response_tag == WED_TAG);
  assign line_write    = buffer_in.write_valid && (buffer_in.write_tag == WED_TAG);
  assign command_taken = command_out.valid && command_out.ready;

  // Only one kind of command leaves this block
  assign command_out.opcode = READ_CL_NA;
  assign command_out.tag    = WED_TAG;
  assign command_out.size   = WED_READ_SIZE;

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      current_state <= WED_RESET;
    end else begin
      current_state <= next_state;
    end
  end

  always_comb begin
    next_state = current_state;
    case (current_state)
      WED_RESET: begin
        next_state = WED_IDLE;
      end
      WED_IDLE: begin
        if (enabled && !wed_valid) begin  // Fetch once per reset
          next_state = WED_REQ;
        end
      end
      WED_REQ: begin
        if (command_taken) begin
          next_state = WED_WAITING_FOR_REQUEST;
        end
      end
      WED_WAITING_FOR_REQUEST: begin
        if (wed_response) begin
          next_state = (response_code == DONE) ? WED_DONE_REQ : WED_RETRY;
        end
      end
      WED_RETRY: begin
        // This attempt is the last one allowed
        if (try_count == TRY_WIDTH'(WED_MAX_TRIES - 1)) begin
          next_state = WED_ERROR;
        end else begin
          next_state = WED_REQ;
        end
      end
      WED_DONE_REQ: begin
        next_state = WED_IDLE;
      end
      WED_ERROR: begin
        next_state = WED_ERROR;  // Held until reset
      end
      default: begin
        next_state = WED_RESET;
      end
    endcase
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      command_out.valid <= 1'b0;
    end else if (command_taken) begin
      command_out.valid <= 1'b0;
    end else if (current_state == WED_REQ) begin
      command_out.valid <= 1'b1;  // Rises one cycle after entering REQ
    end
  end

  always_ff @(posedge clock) begin
    if (current_state == WED_REQ && !command_out.valid) begin
      command_out.address <= wed_address;  // Frozen while valid is high
    end
  end

  always_ff @(posedge clock) begin
    if (current_state == WED_WAITING_FOR_REQUEST && line_write) begin
      case (buffer_in.write_address)
        6'd0:    wed_line[0:511]    <= buffer_in.write_data;
        6'd1:    wed_line[512:1023] <= buffer_in.write_data;
        default: ;  // Outside the 128-byte line
      endcase
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      try_count <= '0;
    end else if (current_state == WED_RETRY) begin
      try_count <= try_count + TRY_WIDTH'(1);
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wed_valid <= 1'b0;
      wed_error <= 1'b0;
    end else begin
      if (current_state == WED_DONE_REQ) begin
        wed_valid <= 1'b1;
      end
      if (current_state == WED_ERROR) begin
        wed_error <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (current_state == WED_DONE_REQ) begin
      wed_request <= map_to_wed(wed_line);  // Appears with wed_valid
    end
  end

endmodule

/* source/command_issue.sv */
`timescale 1ns/1ns

module command_issue (
  input  logic                    clock,
  input  logic                    rstn,
  command_if.sink                 command_in,
  input  logic                    command_credit,
  output logic                    command_valid,
  output capi_pkg::command_opcode command_opcode,
  output logic [0:63]             command_address,
  output capi_pkg::tag_t          command_tag,
  output logic [11:0]             command_size
);

  import capi_pkg::*;

  logic                    held_valid;    // Holding register occupied
  capi_pkg::command_opcode held_opcode;
  logic [0:63]             held_address;
  tag_t                    held_tag;
  logic [11:0]             held_size;
  logic [CREDIT_WIDTH-1:0] credit_count;
  logic                    accept;
  logic                    credit_ready;
  logic                    issue;

  assign command_in.ready = ~held_valid;
  assign accept           = command_in.valid & command_in.ready;

  // A credit returned this cycle can be spent at once
  assign credit_ready = (credit_count != '0) | command_credit;

  // Held command first, otherwise the one accepted now goes straight out
  assign issue = credit_ready & (held_valid | accept);

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      held_valid <= 1'b0;
    end else if (held_valid && credit_ready) begin
      held_valid <= 1'b0;
    end else if (accept && !credit_ready) begin
      held_valid <= 1'b1;  // Parked until a credit returns
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      held_opcode  <= command_in.opcode;
      held_address <= command_in.address;
      held_tag     <= command_in.tag;
      held_size    <= command_in.size;
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      command_valid  <= 1'b0;
      command_opcode <= INVALID;
      command_tag    <= INVALID_TAG;
    end else if (issue) begin
      command_valid  <= 1'b1;
      command_opcode <= held_valid ? held_opcode : command_in.opcode;
      command_tag    <= held_valid ? held_tag : command_in.tag;
    end else begin
      command_valid  <= 1'b0;  // One-cycle pulse
      command_opcode <= INVALID;
      command_tag    <= INVALID_TAG;
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      command_address <= held_valid ? held_address : command_in.address;
      command_size    <= held_valid ? held_size : command_in.size;
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      credit_count <= CREDIT_WIDTH'(HOST_CREDITS);
    end else if (issue && !command_credit) begin
      credit_count <= credit_count - CREDIT_WIDTH'(1);
    end else if (!issue && command_credit) begin
      credit_count <= credit_count + CREDIT_WIDTH'(1);
    end
  end

endmodule

/* source/wed_fetch_top.sv */
`timescale 1ns/1ns

module wed_fetch_top (
  input  logic                    clock,
  input  logic                    rstn,
  input  logic                    enabled,
  input  logic [0:63]             wed_address,
  output logic                    command_valid,
  output capi_pkg::command_opcode command_opcode,
  output logic [0:63]             command_address,
  output capi_pkg::tag_t          command_tag,
  output logic [11:0]             command_size,
  input  logic                    command_credit,
  input  logic                    buffer_write_valid,
  input  capi_pkg::tag_t          buffer_write_tag,
  input  logic [5:0]              buffer_write_address,
  input  logic [0:511]            buffer_write_data,
  input  logic                    response_valid,
  input  capi_pkg::tag_t          response_tag,
  input  capi_pkg::response_code  response_code,
  output logic                    wed_valid,
  output logic                    wed_error,
  output wed_pkg::wed_record      wed_request
);

  command_if command_bus ();  // wed_control to command_issue
  buffer_if  buffer_bus ();   // Host read-buffer writes

  assign buffer_bus.write_valid   = buffer_write_valid;
  assign buffer_bus.write_tag     = buffer_write_tag;
  assign buffer_bus.write_address = buffer_write_address;
  assign buffer_bus.write_data    = buffer_write_data;

  wed_control control0 (
    .clock          (clock),
    .rstn           (rstn),
    .enabled        (enabled),
    .wed_address    (wed_address),
    .buffer_in      (buffer_bus.listener),
    .response_valid (response_valid),
    .response_tag   (response_tag),
    .response_code  (response_code),
    .command_out    (command_bus.source),
    .wed_valid      (wed_valid),
    .wed_error      (wed_error),
    .wed_request    (wed_request)
  );

  command_issue issue0 (
    .clock           (clock),
    .rstn            (rstn),
    .command_in      (command_bus.sink),
    .command_credit  (command_credit),
    .command_valid   (command_valid),
    .command_opcode  (command_opcode),
    .command_address (command_address),
    .command_tag     (command_tag),
    .command_size    (command_size)
  );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clock
);

  // 20 ns period, low for the first half
  initial begin
    clock = 1'b0;
    forever begin
      #10 clock = ~clock;
    end
  end

endmodule

/* verification/wed_checker.sv */
`timescale 1ns/1ns

module wed_checker (
  input logic                              clock,
  input logic                              rstn,
  input logic                              command_valid,
  input logic                              command_credit,
  input logic [capi_pkg::CREDIT_WIDTH-1:0] credit_count,
  input logic                              request_valid,
  input logic                              request_ready,
  input capi_pkg::command_opcode           request_opcode,
  input logic [0:63]                       request_address,
  input capi_pkg::tag_t                    request_tag,
  input logic [11:0]                       request_size
);

  import capi_pkg::*;

  // A command only leaves with a credit in hand, or one returned that cycle
  credit_spent: assert property (@(posedge clock) disable iff (!rstn)
    command_valid |-> ($past(credit_count) != '0) || $past(command_credit))
    else $error("command issued with no credit available");

  credit_bound: assert property (@(posedge clock) disable iff (!rstn)
    credit_count <= CREDIT_WIDTH'(HOST_CREDITS))
    else $error("credit count above the host limit");

  // Internal request holds until the holding register takes it
  request_hold: assert property (@(posedge clock) disable iff (!rstn)
    request_valid && !request_ready |=> request_valid
      && $stable(request_opcode) && $stable(request_address)
      && $stable(request_tag) && $stable(request_size))
    else $error("internal command changed before it was accepted");

endmodule

bind command_issue wed_checker checker0 (
  .clock           (clock),
  .rstn            (rstn),
  .command_valid   (command_valid),
  .command_credit  (command_credit),
  .credit_count    (credit_count),
  .request_valid   (command_in.valid),
  .request_ready   (command_in.ready),
  .request_opcode  (command_in.opcode),
  .request_address (command_in.address),
  .request_tag     (command_in.tag),
  .request_size    (command_in.size)
);

/* verification/wed_tb.sv */
`timescale 1ns/1ns

module wed_tb;

  import wed_pkg::*;

  localparam int TEST_CYCLES    = 150;      // Wait limit for one fetch
  localparam int TIMEOUT_CYCLES = 6 * 200;  // Six tests

  logic                    clock;
  logic                    rstn = 1'b0;
  logic                    enabled = 1'b0;
  logic [0:63]             wed_address = '0;
  logic                    command_valid;
  capi_pkg::command_opcode command_opcode;
  logic [0:63]             command_address;
  capi_pkg::tag_t          command_tag;
  logic [11:0]             command_size;
  logic                    command_credit = 1'b0;
  logic                    buffer_write_valid = 1'b0;
  capi_pkg::tag_t          buffer_write_tag = '0;
  logic [5:0]              buffer_write_address = '0;
  logic [0:511]            buffer_write_data = '0;
  logic                    response_valid = 1'b0;
  capi_pkg::tag_t          response_tag = '0;
  capi_pkg::response_code  response_code = capi_pkg::DONE;
  logic                    wed_valid;
  logic                    wed_error;
  wed_record               wed_request;

  // Test setup, written by the test sequence only
  string                  test_name = "";
  int                     fail_count = 0;    // Failed responses before DONE
  capi_pkg::response_code fail_code = capi_pkg::FAILED;
  int                     credit_delay = 0;  // Negative withholds credits
  bit                     noise = 1'b0;
  int                     credit_requests = 0;
  int                     start_commands = 0;

  logic [0:1023] sent_line = '0;  // Last line written by the host
  int            host_attempts = 0;
  int            cycle_count = 0;
  int            command_total = 0;
  bit            record_seen = 1'b0;
  int            command_errors = 0;
  int            record_errors = 0;
  int            flow_errors = 0;

  tb_clock_gen clock_gen0 (.clock(clock));

  wed_fetch_top dut0 (.*);  // Port names match one to one

  // Expected WED record, line bit 0 is the MSB of item_count
  function automatic wed_record wed_reference(input logic [0:1023] line);
    wed_record rec;
    rec.item_count     = line[0:63];
    rec.source_address = line[64:127];
    rec.dest_address   = line[128:191];
    rec.flags          = line[192:255];
    rec.reserved       = line[256:511];
    return rec;
  endfunction

  task automatic write_buffer(input capi_pkg::tag_t tag, input logic [5:0] address,
                              input logic [0:511] data);
    buffer_write_valid   <= 1'b1;
    buffer_write_tag     <= tag;
    buffer_write_address <= address;
    buffer_write_data    <= data;
    @(posedge clock);
    buffer_write_valid   <= 1'b0;
  endtask

  task automatic send_response(input capi_pkg::tag_t tag, input capi_pkg::response_code code);
    response_valid <= 1'b1;
    response_tag   <= tag;
    response_code  <= code;
    @(posedge clock);
    response_valid <= 1'b0;
  endtask

  // Host side of the read: data halves, then the response
  always begin : host_model
    logic [0:1023] line;
    int            delay;
    @(posedge clock);
    if (!rstn) begin
      host_attempts = 0;
    end else if (command_valid) begin
      for (int i = 0; i < 32; i++) begin
        line[i*32 +: 32] = $urandom;
      end
      sent_line = line;
      delay = 1 + int'($urandom % 6);
      repeat (delay) @(posedge clock);
      if (noise) begin
        write_buffer(8'h22, 6'd0, {16{$urandom}});
        send_response(8'h23, capi_pkg::DONE);  // Must not end the wait
      end
      if (1'($urandom % 2)) begin
        write_buffer(capi_pkg::WED_TAG, 6'd1, line[512:1023]);
        write_buffer(capi_pkg::WED_TAG, 6'd0, line[0:511]);
      end else begin
        write_buffer(capi_pkg::WED_TAG, 6'd0, line[0:511]);
        write_buffer(capi_pkg::WED_TAG, 6'd1, line[512:1023]);
      end
      if (noise) begin
        write_buffer(8'h24, 6'd0, ~line[0:511]);
        // Even address past the line, aliases half 0 if decoded short
        write_buffer(capi_pkg::WED_TAG, 6'(2 * (1 + $urandom % 31)), ~line[0:511]);
      end
      if (host_attempts < fail_count) begin
        send_response(capi_pkg::WED_TAG, fail_code);
      end else begin
        send_response(capi_pkg::WED_TAG, capi_pkg::DONE);
      end
      host_attempts++;
    end
  end

  // Credit returns, per command after credit_delay, or on request
  always begin : credit_return
    int due[$];
    int served;
    @(posedge clock);
    if (!rstn) begin
      due.delete();
      served = credit_requests;
      command_credit <= 1'b0;
    end else begin
      if (command_valid && credit_delay >= 0) begin
        due.push_back(cycle_count + credit_delay);
      end
      if (due.size() > 0 && due[0] <= cycle_count) begin
        void'(due.pop_front());
        command_credit <= 1'b1;
      end else if (served < credit_requests) begin
        served++;
        command_credit <= 1'b1;
      end else begin
        command_credit <= 1'b0;
      end
    end
  end

  always @(posedge clock) begin : command_monitor
    if (rstn && command_valid) begin
      command_total <= command_total + 1;
      assert (command_opcode == capi_pkg::READ_CL_NA && command_tag == capi_pkg::WED_TAG
              && command_size == 12'd128) else begin
        $display("CHECK FAILED at %0t: command opcode %h tag %h size %0d", $time,
                 command_opcode, command_tag, command_size);
        command_errors++;
      end
      assert (command_address == wed_address && enabled) else begin
        $display("CHECK FAILED at %0t: command address %h or enable wrong", $time,
                 command_address);
        command_errors++;
      end
    end
  end

  always @(posedge clock) begin : compare_record
    if (!rstn) begin
      record_seen = 1'b0;
    end else if (wed_valid && !record_seen) begin
      record_seen = 1'b1;
      assert (wed_request == wed_reference(sent_line)) else begin
        $display("CHECK FAILED at %0t: wed_request differs from the reference", $time);
        record_errors++;
      end
    end else if (record_seen) begin
      assert (wed_valid) else begin
        $display("CHECK FAILED at %0t: wed_valid dropped before reset", $time);
        record_errors++;
      end
    end
  end

  always @(posedge clock) begin : watchdog
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycle_count);
      $display("Errors found");
      $finish;
    end
  end

  task automatic expect_true(input bit ok, input string what);
    assert (ok) else begin
      $display("CHECK FAILED at %0t: %s, %s", $time, test_name, what);
      flow_errors++;
    end
  endtask

  task automatic start_test(input string name, input int fails,
                            input capi_pkg::response_code code, input int delay,
                            input bit use_noise);
    @(posedge clock);
    test_name    = name;
    fail_count   = fails;
    fail_code    = code;
    credit_delay = delay;
    noise        = use_noise;
    rstn        <= 1'b0;
    enabled     <= 1'b0;
    wed_address <= {$urandom, $urandom};
    repeat (8) @(posedge clock);
    start_commands = command_total;
    rstn <= 1'b1;
    @(posedge clock);
    expect_true(!command_valid && !wed_valid && !wed_error, "outputs not low after reset");
  endtask

  task automatic wait_done();
    int waited;
    waited = 0;
    while (!(wed_valid || wed_error) && waited < TEST_CYCLES) begin
      @(posedge clock);
      waited++;
    end
    if (!(wed_valid || wed_error)) begin
      $display("Test %s: the WED fetch never completed", test_name);
      flow_errors++;
    end
  endtask

  task automatic run_fetch(input string name, input int fails,
                           input capi_pkg::response_code code, input int delay,
                           input bit use_noise);
    int expected;
    start_test(name, fails, code, delay, use_noise);
    enabled <= 1'b1;
    wait_done();
    repeat (20) @(posedge clock);  // Nothing more may follow
    expected = (fails >= WED_MAX_TRIES) ? WED_MAX_TRIES : fails + 1;
    expect_true(command_total - start_commands == expected, "wrong number of commands");
    if (fails >= WED_MAX_TRIES) begin
      expect_true(wed_error && !wed_valid, "error flag expected");
    end else begin
      expect_true(wed_valid && !wed_error, "record expected");
    end
  endtask

  always begin : test_sequence
    int waited;
    void'($urandom(84));
    start_test("idle", 0, capi_pkg::DONE, 0, 1'b0);
    repeat (20) @(posedge clock);
    expect_true(command_total == start_commands, "command while enabled low");
    expect_true(!wed_valid && !wed_error, "result while enabled low");
    run_fetch("normal", 0, capi_pkg::DONE, 0, 1'b0);
    run_fetch("noise", 0, capi_pkg::DONE, 3, 1'b1);
    run_fetch("one retry", 1, capi_pkg::AERROR, 2, 1'b0);
    // Two failures with credits withheld, third command needs a credit
    start_test("credits", 2, capi_pkg::FAILED, -1, 1'b0);
    enabled <= 1'b1;
    waited = 0;
    while (command_total - start_commands < capi_pkg::HOST_CREDITS && waited < TEST_CYCLES) begin
      @(posedge clock);
      waited++;
    end
    repeat (40) @(posedge clock);
    expect_true(command_total - start_commands == capi_pkg::HOST_CREDITS,
                "commands beyond the credit limit");
    credit_requests++;
    wait_done();
    repeat (20) @(posedge clock);
    expect_true(command_total - start_commands == 3, "no command after the credit");
    expect_true(wed_valid && !wed_error, "record expected");
    run_fetch("exhausted", WED_MAX_TRIES, capi_pkg::PAGED, 0, 1'b0);
    $display("Command errors %0d, record errors %0d, flow errors %0d",
             command_errors, record_errors, flow_errors);
    if (command_errors + record_errors + flow_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* sources.f */
source/capi_pkg.sv
source/wed_pkg.sv
source/command_if.sv
source/buffer_if.sv
source/wed_control.sv
source/command_issue.sv
source/wed_fetch_top.sv
verification/tb_clock_gen.sv
verification/wed_checker.sv
verification/wed_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator and run the WED fetch testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module wed_tb -f sources.f -o wed_sim \
  || { echo "Build failed"; exit 1; }
output="$(./obj_dir/wed_sim)"
echo "$output"
echo "$output" | grep -qx "No errors" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
